//--- src/id_settings.svh
/*
 * sizing and opcode constants for the decode stage
 * include wherever a width or a major opcode is needed
 */

`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// --------------------
// data path sizing
// --------------------
`define ID_XLEN        32
`define ID_REG_ADDR_W  5
// x0 counted, never stored
`define ID_NUM_REGS    32

// --------------------
// rv32i major opcodes
// --------------------
// register-register alu group
`define ID_OPC_OP      7'b0110011
// register-immediate alu group
`define ID_OPC_OP_IMM  7'b0010011
`define ID_OPC_LUI     7'b0110111
`define ID_OPC_AUIPC   7'b0010111
`define ID_OPC_LOAD    7'b0000011

`endif

//--- src/id_pkg.sv
/*
 * types shared by the decode stage and its neighbours
 * import into any module that touches fetch, write-back or decoded control
 */

`include "id_settings.svh"

package id_pkg;

    // alu operation handed to execute
    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    // unit that completes the instruction
    typedef enum logic {
        zone_alu,
        zone_loadq
    } zone_e;

    typedef logic [`ID_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`ID_XLEN-1:0]       xdata_t;

    // one fetched instruction from the prefetch unit
    typedef struct packed {
        xdata_t ins;
        xdata_t pc;
        logic   ferr;
    } fetch_t;

    // register write-back port
    typedef struct packed {
        logic      wr;
        reg_addr_t addr;
        xdata_t    data;
    } wb_port_t;

    // control handed to execute
    typedef struct packed {
        zone_e     zone;
        alu_op_e   alu_op;
        reg_addr_t regd_addr;
        logic [2:0] funct3;
        logic      uerr;
        logic      ferr;
    } exs_ctrl_t;

    // decoder output, ferr joins later from the fetch
    typedef struct packed {
        zone_e      zone;
        alu_op_e    alu_op;
        reg_addr_t  regd_addr;
        logic [2:0] funct3;
        logic       uerr;
        logic       regd_tgt;
        reg_addr_t  regs1_addr;
        logic       regs1_rd;
        reg_addr_t  regs2_addr;
        logic       regs2_rd;
        xdata_t     imm;
        logic       sels1_pc;
        logic       sels1_zero;
        logic       sels2_imm;
    } dec_t;

endpackage

//--- src/rv32i_decoder.sv
/*
 * combinational rv32i decoder for the op, op-imm, lui, auipc and load groups
 * anything else comes out flagged as an undefined instruction
 */

`timescale 1ns/1ps

`include "id_settings.svh"

module rv32i_decoder import id_pkg::*; (
    input  xdata_t ins_i,
    output dec_t   dec_o
);

    // --------------------
    // instruction fields
    // --------------------
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xdata_t     imm_i_type;
    xdata_t     imm_u_type;

    assign opcode = ins_i[6:0];
    assign funct3 = ins_i[14:12];
    assign funct7 = ins_i[31:25];

    // i-type, sign extended from bit 31
    assign imm_i_type = {{(`ID_XLEN-12){ins_i[31]}}, ins_i[31:20]};
    // u-type, upper 20 bits with zero fill
    assign imm_u_type = {ins_i[31:12], 12'b0};

    // funct3 onto alu op
    // alt picks sub over add and sra over srl
    function automatic alu_op_e alu_op_map(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = alt ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    // --------------------
    // decode
    // --------------------
    always_comb begin
        dec_o            = '0;
        dec_o.zone       = zone_alu;
        dec_o.alu_op     = alu_add;
        dec_o.regd_addr  = ins_i[11:7];
        dec_o.funct3     = funct3;
        dec_o.regs1_addr = ins_i[19:15];
        dec_o.regs2_addr = ins_i[24:20];

        case (opcode)
            `ID_OPC_OP: begin
                dec_o.regd_tgt = 1'b1;
                dec_o.regs1_rd = 1'b1;
                dec_o.regs2_rd = 1'b1;
                dec_o.alu_op   = alu_op_map(funct3, funct7[5]);
            end
            `ID_OPC_OP_IMM: begin
                dec_o.regd_tgt  = 1'b1;
                dec_o.regs1_rd  = 1'b1;
                dec_o.imm       = imm_i_type;
                dec_o.sels2_imm = 1'b1;
                // only the right shift uses funct7, addi has no subtract form
                dec_o.alu_op    = alu_op_map(funct3, (funct3 == 3'b101) && funct7[5]);
            end
            `ID_OPC_LUI: begin
                // 0 + imm
                dec_o.regd_tgt   = 1'b1;
                dec_o.imm        = imm_u_type;
                dec_o.sels1_zero = 1'b1;
                dec_o.sels2_imm  = 1'b1;
            end
            `ID_OPC_AUIPC: begin
                // pc + imm
                dec_o.regd_tgt  = 1'b1;
                dec_o.imm       = imm_u_type;
                dec_o.sels1_pc  = 1'b1;
                dec_o.sels2_imm = 1'b1;
            end
            `ID_OPC_LOAD: begin
                // address is rs1 + offset, data comes back through the queue
                dec_o.zone      = zone_loadq;
                dec_o.regd_tgt  = 1'b1;
                dec_o.regs1_rd  = 1'b1;
                dec_o.imm       = imm_i_type;
                dec_o.sels2_imm = 1'b1;
            end
            default: begin
                // no reads, no target, so no hazard and no scoreboard entry
                dec_o.uerr = 1'b1;
            end
        endcase
    end

endmodule

//--- src/load_scoreboard.sv
/*
 * pending-load flags for registers 1 to 31
 * stalls a fetch that reads or targets a register still waiting on a load
 */

`timescale 1ns/1ps

`include "id_settings.svh"

module load_scoreboard import id_pkg::*; (
    input  logic     clk_i,
    input  logic     resetb_i,
    input  logic     dav_i,
    input  logic     accept_i,
    input  dec_t     dec_i,
    input  wb_port_t exs_wb_i,
    input  logic     cncl_load_i,
    input  wb_port_t lsq_wb_i,
    output logic     stall_o
);

    // one flag per stored register, x0 never pends
    logic [`ID_NUM_REGS-1:1] pending_q;
    logic                    s1_hit;
    logic                    s2_hit;
    logic                    rd_hit;

    // --------------------
    // hazard detect
    // --------------------
    // zero check first keeps the x0 index out of the vector
    assign s1_hit = dec_i.regs1_rd && (dec_i.regs1_addr != '0) && pending_q[dec_i.regs1_addr];
    assign s2_hit = dec_i.regs2_rd && (dec_i.regs2_addr != '0) && pending_q[dec_i.regs2_addr];
    // second load or alu write to the same rd would clear the flag too early
    assign rd_hit = dec_i.regd_tgt && (dec_i.regd_addr != '0) && pending_q[dec_i.regd_addr];

    assign stall_o = dav_i & (s1_hit | s2_hit | rd_hit);

    // --------------------
    // flag update
    // --------------------
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            pending_q <= '0;
        end else begin
            // load accepted, result now owed by the queue
            if (accept_i && dec_i.regd_tgt && dec_i.zone == zone_loadq
                    && dec_i.regd_addr != '0) begin
                pending_q[dec_i.regd_addr] <= 1'b1;
            end
            // execute dropped the load
            if (cncl_load_i && exs_wb_i.addr != '0) begin
                pending_q[exs_wb_i.addr] <= 1'b0;
            end
            // load data written back
            if (lsq_wb_i.wr && lsq_wb_i.addr != '0) begin
                pending_q[lsq_wb_i.addr] <= 1'b0;
            end
        end
    end

endmodule

//--- src/int_regfile.sv
/*
 * integer register file, x1 to x31, two write ports and two read ports
 * read data is registered on the read enable and held otherwise
 */

`timescale 1ns/1ps

`include "id_settings.svh"

module int_regfile import id_pkg::*; (
    input  logic      clk_i,
    input  logic      resetb_i,
    // write ports, a from execute, b from the load/store queue
    input  wb_port_t  wb_a_i,
    input  wb_port_t  wb_b_i,
    // read ports
    input  logic      rd_a_i,
    input  logic      rd_b_i,
    input  reg_addr_t addr_a_i,
    input  reg_addr_t addr_b_i,
    output xdata_t    data_a_o,
    output xdata_t    data_b_o
);

    // x0 is not stored
    xdata_t mem [1:`ID_NUM_REGS-1];

    // --------------------
    // write
    // --------------------
    // b written last so the queue wins a same-register collision
    always_ff @(posedge clk_i) begin
        if (wb_a_i.wr && wb_a_i.addr != '0) begin
            mem[wb_a_i.addr] <= wb_a_i.data;
        end
        if (wb_b_i.wr && wb_b_i.addr != '0) begin
            mem[wb_b_i.addr] <= wb_b_i.data;
        end
    end

    // --------------------
    // read
    // --------------------
    // old contents on a same-edge write, the forward mux covers that case
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            data_a_o <= '0;
            data_b_o <= '0;
        end else begin
            if (rd_a_i) begin
                data_a_o <= (addr_a_i == '0) ? '0 : mem[addr_a_i];
            end
            if (rd_b_i) begin
                data_b_o <= (addr_b_i == '0) ? '0 : mem[addr_b_i];
            end
        end
    end

endmodule

//--- src/operand_forward.sv
/*
 * execute result forwarding for both source operands
 * picks current write-back, then last cycle's write-back, then register file data
 */

`timescale 1ns/1ps

module operand_forward import id_pkg::*; (
    input  logic      clk_i,
    input  logic      resetb_i,
    input  wb_port_t  exs_wb_i,
    // source addresses delayed to line up with the read data
    input  reg_addr_t addr_s1_i,
    input  reg_addr_t addr_s2_i,
    input  xdata_t    rf_s1_i,
    input  xdata_t    rf_s2_i,
    output xdata_t    s1_o,
    output xdata_t    s2_o
);

    // last cycle's execute write-back
    wb_port_t fwd_q;

    // --------------------
    // forwarding register
    // --------------------
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            fwd_q <= '0;
        end else begin
            fwd_q <= exs_wb_i;
        end
    end

    // newest copy of one source register
    function automatic xdata_t fwd_select(input reg_addr_t addr, input xdata_t rf_data);
        xdata_t sel;
        if (addr == '0) begin
            // x0 always reads zero from the file
            sel = rf_data;
        end else if (exs_wb_i.wr && exs_wb_i.addr == addr) begin
            sel = exs_wb_i.data;
        end else if (fwd_q.wr && fwd_q.addr == addr) begin
            sel = fwd_q.data;
        end else begin
            sel = rf_data;
        end
        return sel;
    endfunction

    // --------------------
    // forwarding muxes
    // --------------------
    assign s1_o = fwd_select(addr_s1_i, rf_s1_i);
    assign s2_o = fwd_select(addr_s2_i, rf_s2_i);

endmodule

//--- src/id_stage.sv
/*
 * rv32i decode stage between the prefetch unit and execute
 * decodes, reads and forwards operands, stalls on pending loads, one cycle latency
 */

`timescale 1ns/1ps

module id_stage import id_pkg::*; (
    input  logic      clk_i,
    input  logic      resetb_i,
    // prefetch side
    input  logic      pfu_dav_i,
    output logic      pfu_ack_o,
    input  fetch_t    pfu_fetch_i,
    // execute side
    output logic      exs_valid_o,
    input  logic      exs_stall_i,
    output exs_ctrl_t exs_ctrl_o,
    output xdata_t    exs_pc_o,
    output xdata_t    exs_operand_left_o,
    output xdata_t    exs_operand_right_o,
    // write-back
    input  wb_port_t  exs_wb_i,
    input  wb_port_t  lsq_wb_i,
    input  logic      exs_regd_cncl_load_i
);

    dec_t      dec;
    logic      ids_stall;
    logic      exs_stall;
    logic      accept;
    xdata_t    rf_s1;
    xdata_t    rf_s2;
    xdata_t    fwd_s1;
    xdata_t    fwd_s2;
    // id register stage
    xdata_t    imm_q;
    logic      sels1_pc_q;
    logic      sels1_zero_q;
    logic      sels2_imm_q;
    reg_addr_t regs1_addr_q;
    reg_addr_t regs2_addr_q;

    // --------------------
    // accept logic
    // --------------------
    // execute only pushes back on a valid output
    assign exs_stall = exs_stall_i & exs_valid_o;
    assign pfu_ack_o = pfu_dav_i & ~ids_stall & ~exs_stall;
    assign accept    = pfu_ack_o;

    rv32i_decoder rv32i_decoder_inst (
        .ins_i (pfu_fetch_i.ins),
        .dec_o (dec)
    );

    load_scoreboard load_scoreboard_inst (
        .clk_i       (clk_i),
        .resetb_i    (resetb_i),
        .dav_i       (pfu_dav_i),
        .accept_i    (accept),
        .dec_i       (dec),
        .exs_wb_i    (exs_wb_i),
        .cncl_load_i (exs_regd_cncl_load_i),
        .lsq_wb_i    (lsq_wb_i),
        .stall_o     (ids_stall)
    );

    // reads launch with the accept, data lands with the id register
    int_regfile int_regfile_inst (
        .clk_i    (clk_i),
        .resetb_i (resetb_i),
        .wb_a_i   (exs_wb_i),
        .wb_b_i   (lsq_wb_i),
        .rd_a_i   (accept & dec.regs1_rd),
        .rd_b_i   (accept & dec.regs2_rd),
        .addr_a_i (dec.regs1_addr),
        .addr_b_i (dec.regs2_addr),
        .data_a_o (rf_s1),
        .data_b_o (rf_s2)
    );

    operand_forward operand_forward_inst (
        .clk_i     (clk_i),
        .resetb_i  (resetb_i),
        .exs_wb_i  (exs_wb_i),
        .addr_s1_i (regs1_addr_q),
        .addr_s2_i (regs2_addr_q),
        .rf_s1_i   (rf_s1),
        .rf_s2_i   (rf_s2),
        .s1_o      (fwd_s1),
        .s2_o      (fwd_s2)
    );

    // --------------------
    // id register stage
    // --------------------
    // valid set on accept, held while execute stalls, dropped otherwise
    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            exs_valid_o <= 1'b0;
        end else if (accept) begin
            exs_valid_o <= 1'b1;
        end else if (!exs_stall) begin
            exs_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            exs_ctrl_o.zone      <= dec.zone;
            exs_ctrl_o.alu_op    <= dec.alu_op;
            exs_ctrl_o.regd_addr <= dec.regd_addr;
            exs_ctrl_o.funct3    <= dec.funct3;
            exs_ctrl_o.uerr      <= dec.uerr;
            exs_ctrl_o.ferr      <= pfu_fetch_i.ferr;
            exs_pc_o             <= pfu_fetch_i.pc;
            imm_q                <= dec.imm;
            sels1_pc_q           <= dec.sels1_pc;
            sels1_zero_q         <= dec.sels1_zero;
            sels2_imm_q          <= dec.sels2_imm;
            // source addresses follow the read for the forward compare
            regs1_addr_q         <= dec.regs1_addr;
            regs2_addr_q         <= dec.regs2_addr;
        end
    end

    // --------------------
    // operand select
    // --------------------
    // left is pc for auipc, zero for lui, rs1 otherwise
    always_comb begin
        if (sels1_pc_q) begin
            exs_operand_left_o = exs_pc_o;
        end else if (sels1_zero_q) begin
            exs_operand_left_o = '0;
        end else begin
            exs_operand_left_o = fwd_s1;
        end
    end

    // right is the immediate or rs2
    always_comb begin
        if (sels2_imm_q) begin
            exs_operand_right_o = imm_q;
        end else begin
            exs_operand_right_o = fwd_s2;
        end
    end

endmodule

//--- bench/id_stage_sva.sv
/*
 * handshake and scoreboard assertions, bound into id_stage
 */

`timescale 1ns/1ps

`include "id_settings.svh"

module id_stage_sva import id_pkg::*; (
    input logic      clk_i,
    input logic      resetb_i,
    input logic      pfu_ack_o,
    input logic      exs_valid_o,
    input logic      exs_stall_i,
    input exs_ctrl_t exs_ctrl_o,
    input xdata_t    exs_pc_o,
    input xdata_t    exs_operand_left_o,
    input xdata_t    exs_operand_right_o,
    input logic      accept,
    input dec_t      dec,
    // pending-load flags from the scoreboard
    input logic [`ID_NUM_REGS-1:1] pending_q
);

    // no ack while execute holds a valid output
    ack_blocked_by_stall: assert property (@(posedge clk_i) disable iff (!resetb_i)
        !(pfu_ack_o && exs_stall_i && exs_valid_o))
        else $error("ack raised while execute stalls a valid output");

    // outputs frozen across a stalled edge
    outputs_hold_on_stall: assert property (@(posedge clk_i) disable iff (!resetb_i)
        (exs_stall_i && exs_valid_o) |=> ($stable(exs_ctrl_o) && $stable(exs_pc_o)
        && $stable(exs_operand_left_o) && $stable(exs_operand_right_o)))
        else $error("execute outputs moved while stalled");

    // a load accepted onto a pending rd would set a flag twice
    no_double_pend: assert property (@(posedge clk_i) disable iff (!resetb_i)
        (accept && dec.zone == zone_loadq && dec.regd_tgt && dec.regd_addr != '0)
        |-> !pending_q[dec.regd_addr])
        else $error("load accepted onto an already pending register");

endmodule

//--- bench/tb_id_stage.sv
/*
 * table-driven testbench for the decode stage
 * each row is fetched, decoded and checked against a register model
 */

`timescale 1ns/1ps

`include "id_settings.svh"

module tb_id_stage import id_pkg::*; ();

    localparam int NUM_ROWS = 16;
    localparam int CYCLE_LIMIT = NUM_ROWS * 20;
    // operand expectation kinds
    localparam logic [1:0] L_RS1 = 2'd0;
    localparam logic [1:0] L_ZERO = 2'd1;
    localparam logic [1:0] L_PC = 2'd2;
    localparam logic [1:0] SKIP = 2'd3;
    localparam logic [1:0] R_RS2 = 2'd0;
    localparam logic [1:0] R_IMM = 2'd1;
    localparam wb_port_t NO_WB = '0;

    typedef struct packed {
        xdata_t     ins;
        xdata_t     pc;
        wb_port_t   wb_now;
        wb_port_t   wb_next;
        wb_port_t   lsq_rel;
        logic       cncl;
        logic [3:0] hold;
        logic [3:0] stall_cyc;
        zone_e      zone;
        alu_op_e    alu;
        logic       uerr;
        logic [1:0] lsel;
        logic [1:0] rsel;
        xdata_t     imm;
    } row_t;

    logic      clk_i;
    logic      resetb_i;
    logic      pfu_dav_i;
    logic      pfu_ack_o;
    fetch_t    pfu_fetch_i;
    logic      exs_valid_o;
    logic      exs_stall_i;
    exs_ctrl_t exs_ctrl_o;
    xdata_t    exs_pc_o;
    xdata_t    exs_operand_left_o;
    xdata_t    exs_operand_right_o;
    wb_port_t  exs_wb_i;
    wb_port_t  lsq_wb_i;
    logic      exs_regd_cncl_load_i;

    row_t   rows [NUM_ROWS];
    xdata_t model [32];
    int     errors;
    int     test_errors;
    int     cycles;
    integer seed;

    id_stage id_stage_inst (.*);

    bind id_stage id_stage_sva id_stage_sva_inst (
        .*,
        .pending_q (load_scoreboard_inst.pending_q)
    );

    always #2 clk_i = ~clk_i;

    // --------------------
    // run limit
    // --------------------
    always @(posedge clk_i) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic xdata_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
            input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd,
            input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic xdata_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
            input logic [2:0] f3, input reg_addr_t rd, input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic xdata_t enc_u(input logic [19:0] imm, input reg_addr_t rd,
            input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
            input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    // x0 stays zero in the model too
    task automatic model_write(input wb_port_t wb);
        if (wb.wr && wb.addr != '0) begin
            model[wb.addr] = wb.data;
        end
    endtask

    // --------------------
    // one table row
    // --------------------
    task automatic apply_row(input int idx);
        row_t      r;
        exs_ctrl_t snap_ctrl;
        xdata_t    snap_pc;
        xdata_t    snap_l;
        xdata_t    snap_r;
        r = rows[idx];
        test_errors = 0;
        pfu_dav_i = 1'b1;
        // odd word addresses carry a fetch error
        pfu_fetch_i = '{ins: r.ins, pc: r.pc, ferr: r.pc[2]};
        exs_wb_i = r.wb_now;
        model_write(r.wb_now);
        // reader of a pending load must wait for the release
        if (r.hold != 0) begin
            repeat (r.hold) begin
                @(negedge clk_i);
                check_value("pfu_ack_o", pfu_ack_o, 1'b0);
                @(posedge clk_i);
                #1;
            end
            lsq_wb_i = r.lsq_rel;
            model_write(r.lsq_rel);
            exs_regd_cncl_load_i = r.cncl;
            if (r.cncl) begin
                exs_wb_i = '{wr: 1'b0, addr: r.ins[19:15], data: '0};
            end
            @(negedge clk_i);
            check_value("pfu_ack_o", pfu_ack_o, 1'b0);
            @(posedge clk_i);
            #1;
            lsq_wb_i = NO_WB;
            exs_wb_i = NO_WB;
            exs_regd_cncl_load_i = 1'b0;
        end
        @(negedge clk_i);
        while (!pfu_ack_o) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #1;
        // next-cycle write-back goes through the forward mux
        exs_wb_i = r.wb_next;
        model_write(r.wb_next);
        if (r.stall_cyc != 0) begin
            exs_stall_i = 1'b1;
            pfu_fetch_i = '{ins: rows[idx+1].ins, pc: rows[idx+1].pc,
                            ferr: rows[idx+1].pc[2]};
        end else begin
            pfu_dav_i = 1'b0;
        end
        #2;
        check_value("exs_valid_o", exs_valid_o, 1'b1);
        check_value("exs_ctrl_o.zone", exs_ctrl_o.zone, r.zone);
        check_value("exs_ctrl_o.alu_op", exs_ctrl_o.alu_op, r.alu);
        check_value("exs_ctrl_o.regd_addr", exs_ctrl_o.regd_addr, r.ins[11:7]);
        check_value("exs_ctrl_o.funct3", exs_ctrl_o.funct3, r.ins[14:12]);
        check_value("exs_ctrl_o.uerr", exs_ctrl_o.uerr, r.uerr);
        check_value("exs_ctrl_o.ferr", exs_ctrl_o.ferr, r.pc[2]);
        check_value("exs_pc_o", exs_pc_o, r.pc);
        case (r.lsel)
            L_RS1:   check_value("exs_operand_left_o", exs_operand_left_o,
                         model[r.ins[19:15]]);
            L_ZERO:  check_value("exs_operand_left_o", exs_operand_left_o, '0);
            L_PC:    check_value("exs_operand_left_o", exs_operand_left_o, r.pc);
            default: ;
        endcase
        case (r.rsel)
            R_RS2:   check_value("exs_operand_right_o", exs_operand_right_o,
                         model[r.ins[24:20]]);
            R_IMM:   check_value("exs_operand_right_o", exs_operand_right_o, r.imm);
            default: ;
        endcase
        // back-pressure, everything must freeze
        if (r.stall_cyc != 0) begin
            snap_ctrl = exs_ctrl_o;
            snap_pc = exs_pc_o;
            snap_l = exs_operand_left_o;
            snap_r = exs_operand_right_o;
            repeat (r.stall_cyc) begin
                @(posedge clk_i);
                #3;
                check_value("pfu_ack_o", pfu_ack_o, 1'b0);
                check_value("exs_valid_o", exs_valid_o, 1'b1);
                check_value("exs_ctrl_o", exs_ctrl_o, snap_ctrl);
                check_value("exs_pc_o", exs_pc_o, snap_pc);
                check_value("exs_operand_left_o", exs_operand_left_o, snap_l);
                check_value("exs_operand_right_o", exs_operand_right_o, snap_r);
            end
        end
        @(posedge clk_i);
        #1;
        exs_wb_i = NO_WB;
        exs_stall_i = 1'b0;
        pfu_dav_i = 1'b0;
        $display("test %0d %s", idx + 1, (test_errors == 0) ? "ok" : "failed");
    endtask

    // --------------------
    // stimulus table
    // --------------------
    task automatic build_table();
        rows[0]  = '{enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, `ID_OPC_OP), 32'h0000_0100, NO_WB,
                     NO_WB, NO_WB, 1'b0, 4'd0, 4'd0, zone_alu, alu_add, 1'b0, L_RS1, R_RS2, '0};
        rows[1]  = '{enc_r(7'h20, 5'd6, 5'd5, 3'd0, 5'd4, `ID_OPC_OP), 32'h0000_0104, NO_WB,
                     NO_WB, NO_WB, 1'b0, 4'd0, 4'd0, zone_alu, alu_sub, 1'b0, L_RS1, R_RS2, '0};
        rows[2]  = '{enc_r(7'h20, 5'd9, 5'd8, 3'd5, 5'd7, `ID_OPC_OP), 32'h0000_0108, NO_WB,
                     NO_WB, NO_WB, 1'b0, 4'd0, 4'd0, zone_alu, alu_sra, 1'b0, L_RS1, R_RS2, '0};
        rows[3]  = '{enc_i(12'hffb, 5'd11, 3'd0, 5'd10, `ID_OPC_OP_IMM), 32'h0000_010c,
                     NO_WB, NO_WB, NO_WB, 1'b0, 4'd0, 4'd0, zone_alu, alu_add, 1'b0, L_RS1,
                     R_IMM, 32'hffff_fffb};
        rows[4]  = '{enc_i(12'h403, 5'd13, 3'd5, 5'd12, `ID_OPC_OP_IMM), 32'h0000_0110,
                     NO_WB, NO_WB, NO_WB, 1'b0, 4'd0, 4'd0, zone_alu, alu_sra, 1'b0, L_RS1,
                     R_IMM, 32'h0000_0403};
        rows[5]  = '{enc_i(12'h7ff, 5'd15, 3'd4, 5'd14, `ID_OPC_OP_IMM), 32'h0000_0114,
                     NO_WB, NO_WB, NO_WB, 1'b0, 4'd0, 4'd0, zone_alu, alu_xor, 1'b0, L_RS1,
                     R_IMM, 32'h0000_07ff};
        rows[6]  = '{enc_u(20'habcde, 5'd16, `ID_OPC_LUI), 32'h0000_0118, NO_WB, NO_WB,
                     NO_WB, 1'b0, 4'd0, 4'd0, zone_alu, alu_add, 1'b0, L_ZERO, R_IMM,
                     32'habcd_e000};
        rows[7]  = '{enc_u(20'h12345, 5'd17, `ID_OPC_AUIPC), 32'h0000_011c, NO_WB, NO_WB,
                     NO_WB, 1'b0, 4'd0, 4'd0, zone_alu, alu_add, 1'b0, L_PC, R_IMM,
                     32'h1234_5000};
        rows[8]  = '{32'h0000_007f, 32'h0000_0120, NO_WB, NO_WB, NO_WB, 1'b0, 4'd0, 4'd0,
                     zone_alu, alu_add, 1'b1, SKIP, SKIP, '0};
        // forward from the accept cycle on rs1, from the next cycle on rs2
        rows[9]  = '{enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd18, `ID_OPC_OP), 32'h0000_0124,
                     '{1'b1, 5'd1, 32'h1111_1111}, '{1'b1, 5'd2, 32'h2222_2222}, NO_WB,
                     1'b0, 4'd0, 4'd0, zone_alu, alu_add, 1'b0, L_RS1, R_RS2, '0};
        rows[10] = '{enc_i(12'h008, 5'd1, 3'd2, 5'd5, `ID_OPC_LOAD), 32'h0000_0128, NO_WB,
                     NO_WB, NO_WB, 1'b0, 4'd0, 4'd0, zone_loadq, alu_add, 1'b0, L_RS1, R_IMM,
                     32'h0000_0008};
        rows[11] = '{enc_r(7'h00, 5'd1, 5'd5, 3'd0, 5'd19, `ID_OPC_OP), 32'h0000_012c,
                     NO_WB, NO_WB, '{1'b1, 5'd5, 32'h5a5a_5a5a}, 1'b0, 4'd2, 4'd0,
                     zone_alu, alu_add, 1'b0, L_RS1, R_RS2, '0};
        rows[12] = '{enc_i(12'h000, 5'd2, 3'd2, 5'd6, `ID_OPC_LOAD), 32'h0000_0130, NO_WB,
                     NO_WB, NO_WB, 1'b0, 4'd0, 4'd0, zone_loadq, alu_add, 1'b0, L_RS1, R_IMM,
                     '0};
        // cancel instead of a queue write, old x6 stays
        rows[13] = '{enc_i(12'h001, 5'd6, 3'd0, 5'd20, `ID_OPC_OP_IMM), 32'h0000_0134,
                     NO_WB, NO_WB, NO_WB, 1'b1, 4'd2, 4'd0, zone_alu, alu_add, 1'b0, L_RS1,
                     R_IMM, 32'h0000_0001};
        rows[14] = '{enc_r(7'h00, 5'd4, 5'd3, 3'd6, 5'd21, `ID_OPC_OP), 32'h0000_0138,
                     NO_WB, NO_WB, NO_WB, 1'b0, 4'd0, 4'd3, zone_alu, alu_or, 1'b0, L_RS1,
                     R_RS2, '0};
        rows[15] = '{enc_r(7'h00, 5'd8, 5'd7, 3'd7, 5'd22, `ID_OPC_OP), 32'h0000_013c,
                     NO_WB, NO_WB, NO_WB, 1'b0, 4'd0, 4'd0, zone_alu, alu_and, 1'b0, L_RS1,
                     R_RS2, '0};
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        clk_i = 1'b0;
        resetb_i = 1'b0;
        pfu_dav_i = 1'b0;
        pfu_fetch_i = '0;
        exs_stall_i = 1'b0;
        exs_wb_i = NO_WB;
        lsq_wb_i = NO_WB;
        exs_regd_cncl_load_i = 1'b0;
        errors = 0;
        test_errors = 0;
        cycles = 0;
        seed = 59;
        model[0] = '0;
        build_table();
        repeat (3) @(posedge clk_i);
        #1;
        resetb_i = 1'b1;

        // idle after reset
        #1;
        check_value("exs_valid_o", exs_valid_o, 1'b0);
        check_value("pfu_ack_o", pfu_ack_o, 1'b0);
        $display("test 0 %s", (test_errors == 0) ? "ok" : "failed");

        // fill x1..x31 through the execute port
        for (int a = 1; a < 32; a++) begin
            @(posedge clk_i);
            #1;
            exs_wb_i = '{wr: 1'b1, addr: a[4:0], data: $random(seed)};
            model_write(exs_wb_i);
        end
        @(posedge clk_i);
        #1;
        exs_wb_i = NO_WB;
        // let the forwarding register drain
        @(posedge clk_i);
        #1;

        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(i);
        end

        $display("summary: %0d tests, %0d errors", NUM_ROWS + 1, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- id_stage.f
+incdir+src
src/id_pkg.sv
src/rv32i_decoder.sv
src/load_scoreboard.sv
src/int_regfile.sv
src/operand_forward.sv
src/id_stage.sv
bench/id_stage_sva.sv
bench/tb_id_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wall -Wno-fatal \
    -f id_stage.f --top-module tb_id_stage -o sim_tb_id_stage

./obj_dir/sim_tb_id_stage > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
